// ==== load_pkg.sv ====
`default_nettype none

package load_pkg;

    localparam int LOAD_BUFFER_SZ = 4;     // Load slots
    localparam int MSHR_COUNT     = 2;     // Outstanding line misses

    typedef logic [5:0]                      tag_t;        // Physical register tag
    typedef logic [$clog2(MSHR_COUNT)-1:0]   mshr_idx_t;
    typedef logic [31:0]                     data_t;
    typedef data_t [1:0]                     line_t;       // Word 0 at the lower address
    typedef logic [28:0]                     line_addr_t;

    // Bit 2 selects unsigned, bits 1:0 give the access size
    typedef logic [2:0] load_func_t;

    localparam load_func_t FUNC_LB  = 3'b000;
    localparam load_func_t FUNC_LH  = 3'b001;
    localparam load_func_t FUNC_LW  = 3'b010;
    localparam load_func_t FUNC_LBU = 3'b100;
    localparam load_func_t FUNC_LHU = 3'b101;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef struct packed {
        line_addr_t line_addr;
        logic       w_idx;      // Word within the line
        logic [1:0] offset;     // Byte within the word
    } load_addr_s;

    typedef union packed {
        logic [31:0] flat;
        load_addr_s  f;
    } load_addr_u;

    typedef struct packed {
        load_addr_u addr;
        load_func_t func;
        tag_t       tag;
        mshr_idx_t  mshr_idx;
        logic [3:0] byte_mask;  // Bytes still waiting for the fill
        data_t      data;
    } load_slot_t;

endpackage

`default_nettype wire

// ==== mshr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mshr_if import load_pkg::*; ();

    logic       req_valid;
    line_addr_t req_line;
    logic       req_ready;    // Free MSHR or mergeable line
    mshr_idx_t  req_idx;      // Allocated or merged index
    logic       fill_valid;   // One-cycle line broadcast
    mshr_idx_t  fill_idx;
    line_t      fill_line;

    modport buffer (
        output req_valid, req_line,
        input  req_ready, req_idx, fill_valid, fill_idx, fill_line
    );

    modport handler (
        input  req_valid, req_line,
        output req_ready, req_idx, fill_valid, fill_idx, fill_line
    );

endinterface

`default_nettype wire

// ==== psel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fixed priority select, bit 0 wins
module psel_gen #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    logic found;

    always_comb begin
        gnt   = '0;
        found = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && !found) begin
                gnt[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== load_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_buffer import load_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          dispatch_valid,
    input  load_addr_u                    dispatch_addr,
    input  load_func_t                    dispatch_func,
    input  tag_t                          dispatch_tag,
    output logic                          dispatch_ready,
    mshr_if.buffer                        mshr,
    output logic  [LOAD_BUFFER_SZ-1:0]    cdb_req,
    input  logic  [LOAD_BUFFER_SZ-1:0]    cdb_gnt,
    output data_t [LOAD_BUFFER_SZ-1:0]    slot_value,
    output tag_t  [LOAD_BUFFER_SZ-1:0]    slot_tag
);

    logic [LOAD_BUFFER_SZ-1:0]       slot_valid;
    logic [LOAD_BUFFER_SZ-1:0]       free_pick;     // One-hot free slot
    logic [LOAD_BUFFER_SZ-1:0]       new_load;
    logic                            slot_free;
    load_slot_t [LOAD_BUFFER_SZ-1:0] slots;
    load_slot_t [LOAD_BUFFER_SZ-1:0] next_slots;

    // Bytes of the word touched by the access
    function automatic logic [3:0] byte_mask_of(input load_func_t func,
                                                input logic [1:0] offset);
        case (mem_size_e'(func[1:0]))
            BYTE:    byte_mask_of = 4'b0001 << offset;
            HALF:    byte_mask_of = 4'b0011 << offset;
            default: byte_mask_of = 4'b1111;
        endcase
    endfunction

    function automatic data_t extend(input data_t raw, input logic [1:0] offset,
                                     input load_func_t func);
        data_t shifted;
        shifted = raw >> {offset, 3'b000};
        case (mem_size_e'(func[1:0]))
            BYTE:    extend = func[2] ? {24'b0, shifted[7:0]}
                                      : {{24{shifted[7]}}, shifted[7:0]};
            HALF:    extend = func[2] ? {16'b0, shifted[15:0]}
                                      : {{16{shifted[15]}}, shifted[15:0]};
            default: extend = shifted;
        endcase
    endfunction

    psel_gen #(
        .WIDTH(LOAD_BUFFER_SZ)
    ) free_picker (
        .req(~slot_valid),
        .gnt(free_pick)
    );

    assign slot_free      = |free_pick;
    assign mshr.req_valid = dispatch_valid && slot_free;
    assign mshr.req_line  = dispatch_addr.f.line_addr;
    assign dispatch_ready = slot_free && mshr.req_ready;
    assign new_load       = (dispatch_valid && dispatch_ready) ? free_pick : '0;

    always_comb begin
        next_slots = slots;
        for (int i = 0; i < LOAD_BUFFER_SZ; i++) begin
            if (new_load[i]) begin
                next_slots[i].addr      = dispatch_addr;
                next_slots[i].func      = dispatch_func;
                next_slots[i].tag       = dispatch_tag;
                next_slots[i].mshr_idx  = mshr.req_idx;
                next_slots[i].byte_mask = byte_mask_of(dispatch_func, dispatch_addr.f.offset);
                next_slots[i].data      = '0;
            end else if (slot_valid[i] && mshr.fill_valid
                         && slots[i].mshr_idx == mshr.fill_idx) begin
                // Take only the bytes still missing from the addressed word
                for (int j = 0; j < 4; j++) begin
                    if (slots[i].byte_mask[j]) begin
                        next_slots[i].data[8*j +: 8] =
                            mshr.fill_line[slots[i].addr.f.w_idx][8*j +: 8];
                        next_slots[i].byte_mask[j]   = 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LOAD_BUFFER_SZ; i++) begin
            cdb_req[i]    = slot_valid[i] && (slots[i].byte_mask == 4'b0000);
            slot_value[i] = extend(slots[i].data, slots[i].addr.f.offset, slots[i].func);
            slot_tag[i]   = slots[i].tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= (slot_valid & ~cdb_gnt) | new_load;   // Free on grant
        end
    end

    always_ff @(posedge clock) begin
        slots <= next_slots;
    end

endmodule

`default_nettype wire

// ==== miss_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_handler import load_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    mshr_if.handler     mshr,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    input  data_t       wb_dat_i,
    input  logic        wb_ack
);

    typedef enum logic [1:0] {IDLE, WORD0, GAP, WORD1} seq_state_e;

    seq_state_e                  state;
    logic       [MSHR_COUNT-1:0] mshr_valid;
    line_addr_t [MSHR_COUNT-1:0] mshr_line;
    logic       [MSHR_COUNT-1:0] merge_hit;
    mshr_idx_t                   head;       // Oldest pending, served next
    mshr_idx_t                   tail;       // Next to allocate
    logic                        alloc;
    line_t                       line_buf;
    load_addr_u                  bus_addr;

    // Entries allocate and free in ring order
    function automatic mshr_idx_t next_idx(input mshr_idx_t idx);
        if (idx == mshr_idx_t'(MSHR_COUNT - 1)) begin
            next_idx = '0;
        end else begin
            next_idx = idx + mshr_idx_t'(1);
        end
    endfunction

    always_comb begin
        mshr.req_idx = tail;
        for (int i = 0; i < MSHR_COUNT; i++) begin
            // A line filling this cycle cannot take new loads
            merge_hit[i] = mshr_valid[i] && (mshr_line[i] == mshr.req_line)
                           && !(mshr.fill_valid && mshr.fill_idx == mshr_idx_t'(i));
            if (merge_hit[i]) begin
                mshr.req_idx = mshr_idx_t'(i);
            end
        end
    end

    assign mshr.req_ready = (|merge_hit) || !mshr_valid[tail];
    assign alloc          = mshr.req_valid && mshr.req_ready && !(|merge_hit);
    assign mshr.fill_idx  = head;
    assign mshr.fill_line = line_buf;

    always_ff @(posedge clock) begin
        if (reset) begin
            mshr_valid <= '0;
            head       <= '0;
            tail       <= '0;
        end else begin
            if (mshr.fill_valid) begin
                mshr_valid[head] <= 1'b0;
                head             <= next_idx(head);
            end
            if (alloc) begin
                mshr_valid[tail] <= 1'b1;
                tail             <= next_idx(tail);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            mshr_line[tail] <= mshr.req_line;
        end
        if (wb_stb && wb_ack) begin
            line_buf[bus_addr.f.w_idx] <= wb_dat_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= IDLE;
            mshr.fill_valid <= 1'b0;
        end else begin
            mshr.fill_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (mshr_valid[head] && !mshr.fill_valid) begin   // Head frees on fill
                        state <= WORD0;
                    end
                end
                WORD0: begin
                    if (wb_ack) begin
                        state <= GAP;
                    end
                end
                GAP: state <= WORD1;    // Bus idle between the two reads
                WORD1: begin
                    if (wb_ack) begin
                        state           <= IDLE;
                        mshr.fill_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        bus_addr.f.line_addr = mshr_line[head];
        bus_addr.f.w_idx     = (state == WORD1);
        bus_addr.f.offset    = 2'b00;
    end

    assign wb_adr = bus_addr.flat;
    assign wb_cyc = (state == WORD0) || (state == WORD1);
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;   // Reads only

endmodule

`default_nettype wire

// ==== cdb_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_select import load_pkg::*; (
    input  logic  [LOAD_BUFFER_SZ-1:0] cdb_req,
    input  data_t [LOAD_BUFFER_SZ-1:0] slot_value,
    input  tag_t  [LOAD_BUFFER_SZ-1:0] slot_tag,
    output logic  [LOAD_BUFFER_SZ-1:0] cdb_gnt,
    output logic                       cdb_valid,
    output tag_t                       cdb_tag,
    output data_t                      cdb_value
);

    psel_gen #(
        .WIDTH(LOAD_BUFFER_SZ)
    ) cdb_arbiter (
        .req(cdb_req),
        .gnt(cdb_gnt)
    );

    assign cdb_valid = |cdb_gnt;

    // One-hot grant, so an AND-OR mux is enough
    always_comb begin
        cdb_tag   = '0;
        cdb_value = '0;
        for (int i = 0; i < LOAD_BUFFER_SZ; i++) begin
            cdb_tag   = cdb_tag   | (slot_tag[i]   & {$bits(tag_t){cdb_gnt[i]}});
            cdb_value = cdb_value | (slot_value[i] & {$bits(data_t){cdb_gnt[i]}});
        end
    end

endmodule

`default_nettype wire

// ==== load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit import load_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        dispatch_valid,
    input  logic [31:0] dispatch_addr,
    input  load_func_t  dispatch_func,
    input  tag_t        dispatch_tag,
    output logic        dispatch_ready,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    input  data_t       wb_dat_i,
    input  logic        wb_ack,
    output logic        cdb_valid,
    output tag_t        cdb_tag,
    output data_t       cdb_value
);

    logic  [LOAD_BUFFER_SZ-1:0] cdb_req;
    logic  [LOAD_BUFFER_SZ-1:0] cdb_gnt;
    data_t [LOAD_BUFFER_SZ-1:0] slot_value;
    tag_t  [LOAD_BUFFER_SZ-1:0] slot_tag;

    mshr_if mshr_bus ();

    load_buffer load_buffer_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_addr  (dispatch_addr),
        .dispatch_func  (dispatch_func),
        .dispatch_tag   (dispatch_tag),
        .dispatch_ready (dispatch_ready),
        .mshr           (mshr_bus.buffer),
        .cdb_req        (cdb_req),
        .cdb_gnt        (cdb_gnt),
        .slot_value     (slot_value),
        .slot_tag       (slot_tag)
    );

    miss_handler miss_handler_i (
        .clock    (clock),
        .reset    (reset),
        .mshr     (mshr_bus.handler),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    cdb_select cdb_select_i (
        .cdb_req    (cdb_req),
        .slot_value (slot_value),
        .slot_tag   (slot_tag),
        .cdb_gnt    (cdb_gnt),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value)
    );

endmodule

`default_nettype wire

// ==== load_unit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit_props (
    input logic        clock,
    input logic        reset,
    input logic        dispatch_valid,
    input logic        dispatch_ready,
    input logic [31:0] dispatch_addr,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [31:0] wb_adr,
    input logic        wb_ack
);

    // Strobe only inside a bus cycle
    stb_in_cycle: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // A read stays on the bus until memory acks it
    stb_held: assert property (@(posedge clock) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("wb_stb or wb_adr changed before wb_ack");

    no_write: assert property (@(posedge clock) disable iff (reset) !wb_we)
        else $error("wb_we raised on the read-only memory port");

    dispatch_held: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_addr))
        else $error("Dispatch dropped or changed a load that was not accepted");

endmodule

`default_nettype wire

// ==== load_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit_tb import load_pkg::*; ();

    localparam int          CLK_PERIOD = 8;
    localparam int          NUM_STIM   = 25;
    localparam logic [31:0] MERGE_ADR  = 32'h0000_2040;   // Word 0 of the merged line
    localparam logic [31:0] STALL_ADR  = 32'h0000_3000;

    typedef struct packed {
        logic [31:0] addr;
        load_func_t  func;
        tag_t        tag;
        logic        drain;     // Wait until nothing is outstanding
        logic        stall;     // Memory holds off acks
        logic        blocked;   // Must not be accepted until memory resumes
        logic        ordered;   // Completes in dispatch order
    } stim_t;

    localparam stim_t STIM [NUM_STIM] = '{
        // address      func      tag    drain stall blocked ordered
        '{32'h0000_1000, FUNC_LB,  6'd0,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1011, FUNC_LB,  6'd1,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1026, FUNC_LB,  6'd2,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1037, FUNC_LB,  6'd3,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1040, FUNC_LBU, 6'd4,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1049, FUNC_LBU, 6'd5,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_105A, FUNC_LBU, 6'd6,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_106F, FUNC_LBU, 6'd7,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h8000_1070, FUNC_LH,  6'd8,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h8000_1086, FUNC_LH,  6'd9,  1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1090, FUNC_LHU, 6'd10, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_10AE, FUNC_LHU, 6'd11, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_10BC, FUNC_LW,  6'd12, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0000_2040, FUNC_LW,  6'd13, 1'b1, 1'b0, 1'b0, 1'b1},
        '{32'h0000_2045, FUNC_LBU, 6'd14, 1'b0, 1'b0, 1'b0, 1'b1},
        '{32'h0000_2042, FUNC_LH,  6'd15, 1'b0, 1'b0, 1'b0, 1'b1},
        '{32'h0000_2047, FUNC_LB,  6'd16, 1'b0, 1'b0, 1'b0, 1'b1},
        '{32'h0000_3000, FUNC_LHU, 6'd17, 1'b1, 1'b1, 1'b0, 1'b1},
        '{32'h0000_3004, FUNC_LW,  6'd18, 1'b0, 1'b1, 1'b0, 1'b1},
        '{32'h0000_3003, FUNC_LBU, 6'd19, 1'b0, 1'b1, 1'b0, 1'b1},
        '{32'h0000_3006, FUNC_LH,  6'd20, 1'b0, 1'b1, 1'b0, 1'b1},
        '{32'h0000_3108, FUNC_LB,  6'd21, 1'b0, 1'b1, 1'b1, 1'b0},   // All slots taken
        '{32'h0000_4010, FUNC_LW,  6'd22, 1'b1, 1'b1, 1'b0, 1'b0},
        '{32'h0000_5020, FUNC_LHU, 6'd23, 1'b0, 1'b1, 1'b0, 1'b0},
        '{32'h0000_6031, FUNC_LB,  6'd24, 1'b0, 1'b1, 1'b1, 1'b0}    // Both MSHRs taken
    };

    logic        clock;
    logic        reset;
    logic        dispatch_valid;
    logic [31:0] dispatch_addr;
    load_func_t  dispatch_func;
    tag_t        dispatch_tag;
    logic        dispatch_ready;
    logic        dispatch_ordered;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    data_t       wb_dat_i = '0;
    logic        wb_ack   = 1'b0;
    logic        cdb_valid;
    tag_t        cdb_tag;
    data_t       cdb_value;

    logic        mem_stall = 1'b0;
    logic        counting  = 1'b0;
    int          wait_left = 0;
    int          seed      = 32'h5524_9901;
    bit          pending [64];
    data_t       exp_value [64];
    tag_t        order_q [$];
    int          outstanding   = 0;
    int          merge_fetches = 0;
    int          stall_fetches = 0;

    load_unit dut_i (.*);

    bind load_unit load_unit_props props_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_addr  (dispatch_addr),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack)
    );

    // Memory contents are a hash of the word address
    function automatic data_t mem_word(input logic [31:0] adr);
        mem_word = (adr * 32'h9E37_79B9) ^ adr;
    endfunction

    function automatic data_t expected_load(input logic [31:0] addr, input load_func_t func);
        data_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        word = mem_word({addr[31:2], 2'b00});
        b    = word[{addr[1:0], 3'b000} +: 8];
        h    = word[{addr[1], 4'b0000} +: 16];
        case (func)
            FUNC_LB:  expected_load = {{24{b[7]}}, b};
            FUNC_LBU: expected_load = {24'h0, b};
            FUNC_LH:  expected_load = {{16{h[15]}}, h};
            FUNC_LHU: expected_load = {16'h0, h};
            default:  expected_load = word;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED time %0t: %s is %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED time %0t: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    task automatic wait_for_drain();
        while (outstanding != 0) begin
            @(negedge clock);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic dispatch_load(input stim_t s);
        logic accepted;
        accepted         = 1'b0;
        mem_stall       <= s.stall;
        dispatch_valid   = 1'b1;
        dispatch_addr    = s.addr;
        dispatch_func    = s.func;
        dispatch_tag     = s.tag;
        dispatch_ordered = s.ordered;
        if (s.blocked) begin
            repeat (12) begin
                #(CLK_PERIOD / 4);
                if (dispatch_ready) begin
                    fail_run("Dispatch accepted a load while slots or MSHRs were all busy");
                end
                @(negedge clock);
            end
            mem_stall <= 1'b0;
        end
        while (!accepted) begin
            #(CLK_PERIOD / 4);      // Handshake settled before the rising edge
            accepted = dispatch_ready;
            @(negedge clock);
        end
        dispatch_valid = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(NUM_STIM * 200 * CLK_PERIOD);
        fail_run("Timeout: the loads did not all complete in time");
    end

    // Wishbone slave with 0 to 3 wait states
    always @(negedge clock) begin
        wb_ack <= 1'b0;
        if (wb_cyc && wb_stb && !wb_ack && !mem_stall) begin
            if (!counting) begin
                wait_left = $unsigned($random(seed)) % 4;
                counting  = 1'b1;
            end
            if (wait_left == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem_word(wb_adr);
                counting  = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // Scoreboard by tag
    always @(negedge clock) begin
        #(CLK_PERIOD / 4);      // Same sample point as the dispatch handshake
        if (!reset) begin
            if (cdb_valid) begin
                if (!pending[cdb_tag]) begin
                    fail_run($sformatf("CDB returned tag %0d with no load outstanding for it",
                                       cdb_tag));
                end
                check_value("cdb_value", cdb_value, exp_value[cdb_tag]);
                if (order_q.size() > 0) begin
                    check_tag("cdb_tag", cdb_tag, order_q.pop_front());
                end
                pending[cdb_tag] = 1'b0;
                outstanding      = outstanding - 1;
            end
            if (dispatch_valid && dispatch_ready) begin
                pending[dispatch_tag]   = 1'b1;
                exp_value[dispatch_tag] = expected_load(dispatch_addr, dispatch_func);
                outstanding             = outstanding + 1;
                if (dispatch_ordered) begin
                    order_q.push_back(dispatch_tag);
                end
            end
            if (wb_stb && wb_ack && wb_adr == MERGE_ADR) merge_fetches++;
            if (wb_stb && wb_ack && wb_adr == STALL_ADR) stall_fetches++;
        end
    end

    initial begin
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_addr    = '0;
        dispatch_func    = FUNC_LW;
        dispatch_tag     = '0;
        dispatch_ordered = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #(CLK_PERIOD / 4);
        if (!dispatch_ready || wb_cyc || cdb_valid) begin
            fail_run("Dispatch not ready or bus and CDB not idle after reset");
        end
        @(negedge clock);
        for (int i = 0; i < NUM_STIM; i++) begin
            if (STIM[i].drain) begin
                wait_for_drain();
            end
            dispatch_load(STIM[i]);
        end
        wait_for_drain();
        repeat (20) @(negedge clock);   // CDB must stay quiet
        check_value("fetches of the merged line", data_t'(merge_fetches), 32'd1);
        check_value("fetches of the stalled line", data_t'(stall_fetches), 32'd1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
load_pkg.sv
mshr_if.sv
psel_gen.sv
load_buffer.sv
miss_handler.sv
cdb_select.sv
load_unit.sv
load_unit_props.sv
load_unit_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only load_pkg.sv mshr_if.sv psel_gen.sv load_buffer.sv \
		miss_handler.sv cdb_select.sv load_unit.sv --top-module load_unit
	verilator --lint-only --timing -f src.f --top-module load_unit_tb

sim:
	verilator --binary --timing --assert -f src.f --top-module load_unit_tb \
		-o load_unit_sim
	./obj_dir/load_unit_sim

clean:
	rm -rf obj_dir
